// File: sim.f
+incdir+src
src/scalar_pkg.sv
src/decoded_if.sv
src/sync_ram.sv
src/sequencer.sv
src/addr_translator.sv
src/io_ports.sv
src/alu.sv
src/scalar_core.sv
tests/scalar_core_tb.sv

// File: tests/scalar_core_tb.sv
`timescale 1ns/1ps
/* Each program runs from reset and ends in HALT. The input model holds every word
   a program consumes before run goes high. RAM word 50 is cleared by each program. */
`include "scalar_defines.svh"

module scalar_core_tb
    import scalar_pkg::*;
();

    localparam int IN_PORT   = `SC_ADDR_IO_IN;
    localparam int OUT_PORT  = `SC_ADDR_IO_OUT;
    localparam int OFS_A     = `SC_ADDR_OFS_A;
    localparam int OFS_B     = `SC_ADDR_OFS_B;
    localparam int OFS_D     = `SC_ADDR_OFS_D;
    localparam int ZERO_WORD = 50;

    // Instructions executed: alu 9, translation 9, stalls 12, branches 35 at most, halt 3
    localparam int INSTR_TOTAL = 68;
    localparam int MAX_STALL   = 4;
    localparam int CYCLE_LIMIT = 4 * INSTR_TOTAL * (1 + MAX_STALL) + 600;

    logic   clock;
    logic   rst_n;
    logic   run;
    logic   imem_wren;
    addr_t  imem_addr;
    instr_t imem_data;
    logic   io_in_empty;
    word_t  io_in_data;
    logic   io_out_full;
    logic   io_in_rden;
    logic   io_out_wren;
    word_t  io_out_data;
    logic   halted;
    addr_t  pc;

    logic [31:0] lfsr_state = 32'h681aff2a;
    word_t       in_q[$];
    word_t       out_q[$];
    word_t       exp_q[$];
    instr_t      prog[$];
    string       test_name = "reset";
    logic        stall_on = 1'b0;
    logic        in_stall = 1'b0;
    logic        out_stall = 1'b0;
    logic        rd_pending = 1'b0;
    int          in_left = 0;
    int          out_left = 0;
    int          pushed = 0;
    int          rden_cnt = 0;
    int          strobe_cnt = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests_done = 0;
    int          err_mark = 0;

    scalar_core dut_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .imem_wren   (imem_wren),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .io_in_empty (io_in_empty),
        .io_in_data  (io_in_data),
        .io_out_full (io_out_full),
        .io_in_rden  (io_in_rden),
        .io_out_wren (io_out_wren),
        .io_out_data (io_out_data),
        .halted      (halted),
        .pc          (pc)
    );

    always #4 clock = ~clock;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // I/O port model and monitors

    always @(posedge clock) begin
        #1;
        if (rd_pending) begin
            if (in_q.size() > 0) begin
                void'(in_q.pop_front());
            end
            rd_pending = 1'b0;
        end
        if (stall_on) begin
            if (in_left == 0) begin
                in_stall = rand_bits(1);
                in_left  = 1 + rand_bits(2);
            end
            if (out_left == 0) begin
                out_stall = rand_bits(1);
                out_left  = 1 + rand_bits(2);
            end
            in_left--;
            out_left--;
        end else begin
            in_stall  = 1'b0;
            out_stall = 1'b0;
            in_left   = 0;
            out_left  = 0;
        end
        io_in_empty = in_stall || (in_q.size() == 0);
        io_in_data  = (in_q.size() > 0) ? in_q[0] : '0;
        io_out_full = out_stall;
    end

    // Strobes are one cycle wide, so one mid-cycle sample each
    always @(negedge clock) begin
        if (rst_n) begin
            if (io_in_rden) begin
                rd_pending = 1'b1;
                rden_cnt++;
            end
            if (io_out_wren) begin
                out_q.push_back(io_out_data);
            end
            if (io_in_rden || io_out_wren) begin
                strobe_cnt++;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: %0d cycles passed during test %s", cycles, test_name);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) io_in_rden |-> !io_in_empty)
        else begin
            errors++;
            $display("Read strobe pulsed while the input port was empty in %s", test_name);
        end

    assert property (@(posedge clock) disable iff (!rst_n) io_out_wren |-> !io_out_full)
        else begin
            errors++;
            $display("Write strobe pulsed while the output port was full in %s", test_name);
        end

    assert property (@(posedge clock) disable iff (!rst_n) halted |-> !(io_in_rden || io_out_wren))
        else begin
            errors++;
            $display("A strobe pulsed while the core was halted in %s", test_name);
        end

    // ------------------------------------------------------------
    // Helpers

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        run   = 1'b0;
        rst_n = 1'b0;
        repeat (5) tick();
        rst_n = 1'b1;
        tick();
    endtask

    task automatic start_test(string name);
        test_name = name;
        apply_reset();
        in_q.delete();
        out_q.delete();
        exp_q.delete();
        prog.delete();
        pushed   = 0;
        rden_cnt = 0;
        err_mark = errors;
    endtask

    task automatic push_input(word_t w);
        in_q.push_back(w);
        pushed++;
    endtask

    task automatic add_instr(opcode_t op, int d, int a, int b);
        instr_t ins;
        ins.op = op;
        ins.d  = addr_t'(d);
        ins.a  = addr_t'(a);
        ins.b  = addr_t'(b);
        prog.push_back(ins);
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            imem_wren = 1'b1;
            imem_addr = addr_t'(i);
            imem_data = prog[i];
            tick();
        end
        imem_wren = 1'b0;
        tick();
    endtask

    task automatic run_until_halt();
        run = 1'b1;
        while (!halted) begin
            tick();
        end
    endtask

    task automatic compare_word(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp == act)
            else begin
                errors++;
                $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
            end
    endtask

    task automatic close_test();
        compare_word("output count", exp_q.size(), out_q.size());
        foreach (exp_q[i]) begin
            if (i < out_q.size()) begin
                compare_word($sformatf("output %0d", i), exp_q[i], out_q[i]);
            end
        end
        compare_word("words consumed", pushed, rden_cnt);
        tests_done++;
        $display("test %s done with %0d failures", test_name, errors - err_mark);
    endtask

    // ------------------------------------------------------------
    // Tests

    task automatic test_alu();
        word_t x;
        word_t y;
        start_test("alu");
        x = word_t'(rand_bits(16));
        y = word_t'(rand_bits(16));
        push_input(x);
        push_input(y);
        add_instr(AND, ZERO_WORD, OFS_A, ZERO_WORD);
        add_instr(ADD, 40, IN_PORT, ZERO_WORD);
        add_instr(ADD, 41, IN_PORT, ZERO_WORD);
        add_instr(ADD, OUT_PORT, 40, 41);
        add_instr(SUB, OUT_PORT, 40, 41);
        add_instr(AND, OUT_PORT, 40, 41);
        add_instr(OR, OUT_PORT, 40, 41);
        add_instr(XOR, OUT_PORT, 40, 41);
        add_instr(HALT, 0, 0, 0);
        exp_q.push_back(word_t'(x + y));
        exp_q.push_back(word_t'(x - y));
        exp_q.push_back(x & y);
        exp_q.push_back(x | y);
        exp_q.push_back(x ^ y);
        load_program();
        run_until_halt();
        close_test();
    endtask

    task automatic test_translation();
        int    oa;
        int    ob;
        int    od;
        word_t v1;
        word_t v2;
        start_test("translation");
        oa = rand_bits(5);
        ob = rand_bits(5);
        od = rand_bits(5);
        v1 = word_t'(rand_bits(16));
        v2 = word_t'(rand_bits(16));
        push_input(word_t'(oa));
        push_input(word_t'(ob));
        push_input(word_t'(od));
        push_input(v1);
        push_input(v2);
        add_instr(AND, ZERO_WORD, OFS_A, ZERO_WORD);
        add_instr(ADD, OFS_A, IN_PORT, ZERO_WORD);
        add_instr(ADD, OFS_B, IN_PORT, ZERO_WORD);
        add_instr(ADD, OFS_D, IN_PORT, ZERO_WORD);
        // Stored at (3 + od) and (7 + od) modulo 32
        add_instr(ADD, 3, IN_PORT, ZERO_WORD);
        add_instr(ADD, 7, IN_PORT, ZERO_WORD);
        add_instr(ADD, OUT_PORT, (3 + od + 32 - oa) % 32, ZERO_WORD);
        add_instr(ADD, OUT_PORT, OFS_A, (7 + od + 32 - ob) % 32);
        add_instr(HALT, 0, 0, 0);
        exp_q.push_back(v1);
        exp_q.push_back(v2);
        load_program();
        run_until_halt();
        close_test();
    endtask

    task automatic test_stalls();
        word_t w;
        start_test("stalls");
        add_instr(AND, ZERO_WORD, OFS_A, ZERO_WORD);
        for (int i = 0; i < 10; i++) begin
            w = word_t'(rand_bits(16));
            push_input(w);
            exp_q.push_back(w);
            add_instr(ADD, OUT_PORT, IN_PORT, ZERO_WORD);
        end
        add_instr(HALT, 0, 0, 0);
        load_program();
        @(negedge clock) stall_on = 1'b1;
        tick();
        run_until_halt();
        @(negedge clock) stall_on = 1'b0;
        close_test();
    endtask

    task automatic test_branches();
        int n;
        start_test("branches");
        n = 1 + rand_bits(3);
        push_input(word_t'(n));
        push_input(word_t'(1));
        add_instr(AND, ZERO_WORD, OFS_A, ZERO_WORD);
        add_instr(ADD, 42, IN_PORT, ZERO_WORD);
        add_instr(ADD, 43, IN_PORT, ZERO_WORD);
        // Loop body at 3, exit at 7
        add_instr(SUB, 42, 42, 43);
        add_instr(ADD, OUT_PORT, 42, ZERO_WORD);
        add_instr(JZ, 7, 42, 0);
        add_instr(JMP, 3, 0, 0);
        add_instr(HALT, 0, 0, 0);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back(word_t'(i));
        end
        load_program();
        run_until_halt();
        close_test();
    endtask

    task automatic test_halt_reset();
        word_t w;
        start_test("halt_reset");
        w = word_t'(rand_bits(16));
        push_input(w);
        exp_q.push_back(w);
        add_instr(AND, ZERO_WORD, OFS_A, ZERO_WORD);
        add_instr(ADD, OUT_PORT, IN_PORT, ZERO_WORD);
        add_instr(HALT, 0, 0, 0);
        load_program();
        run_until_halt();
        strobe_cnt = 0;
        repeat (20) tick();
        compare_word("halted", 1, halted);
        compare_word("strobes while halted", 0, strobe_cnt);
        compare_word("pc while halted", 2, pc);
        apply_reset();
        compare_word("halted after reset", 0, halted);
        compare_word("pc after reset", 0, pc);
        compare_word("io_in_rden after reset", 0, io_in_rden);
        compare_word("io_out_wren after reset", 0, io_out_wren);
        close_test();
    endtask

    initial begin
        clock       = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        imem_wren   = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        io_in_empty = 1'b1;
        io_in_data  = '0;
        io_out_full = 1'b0;
        test_alu();
        test_translation();
        test_stalls();
        test_branches();
        test_halt_reset();
        $display("tests %0d, checks %0d, failures %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src/scalar_core.sv
`timescale 1ns/1ps
/* Single-thread scalar core. Load the instruction memory only while run is low;
   results go to both A and B memories at D. */
`include "scalar_defines.svh"

module scalar_core
    import scalar_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   run,
    input  logic   imem_wren,
    input  addr_t  imem_addr,
    input  instr_t imem_data,
    input  logic   io_in_empty,
    input  word_t  io_in_data,
    input  logic   io_out_full,
    output logic   io_in_rden,
    output logic   io_out_wren,
    output word_t  io_out_data,
    output logic   halted,
    output addr_t  pc
);

    logic   fetch_en;
    logic   decode_en;
    logic   commit;
    logic   io_ready;
    wb_t    wb;
    instr_t instr;
    word_t  a_rdata;
    word_t  b_rdata;
    word_t  a_value;
    word_t  result;

    decoded_if dec ();

    // ----------------------------------------------------------
    // Control

    sequencer u_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .run       (run),
        .io_ready  (io_ready),
        .a_value   (a_value),
        .result    (result),
        .dec       (dec.sink),
        .pc        (pc),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .wb        (wb),
        .commit    (commit),
        .halted    (halted)
    );

    sync_ram #(.entry_t(instr_t), .DEPTH(`SC_MEM_DEPTH)) u_imem (
        .clock (clock),
        .wren  (imem_wren && !run),
        .waddr (imem_addr),
        .wdata (imem_data),
        .raddr (pc),
        .rdata (instr)
    );

    addr_translator u_translator (
        .clock     (clock),
        .rst_n     (rst_n),
        .decode_en (decode_en),
        .instr     (instr),
        .wb        (wb),
        .dec       (dec.source)
    );

    // ----------------------------------------------------------
    // Data path

    sync_ram #(.entry_t(word_t), .DEPTH(`SC_MEM_DEPTH)) u_a_mem (
        .clock (clock),
        .wren  (wb.wren),
        .waddr (wb.addr),
        .wdata (wb.data),
        .raddr (dec.a_addr),
        .rdata (a_rdata)
    );

    sync_ram #(.entry_t(word_t), .DEPTH(`SC_MEM_DEPTH)) u_b_mem (
        .clock (clock),
        .wren  (wb.wren),
        .waddr (wb.addr),
        .wdata (wb.data),
        .raddr (dec.b_addr),
        .rdata (b_rdata)
    );

    io_ports u_io_ports (
        .clock       (clock),
        .rst_n       (rst_n),
        .dec         (dec.sink),
        .a_rdata     (a_rdata),
        .commit      (commit),
        .wb          (wb),
        .io_in_empty (io_in_empty),
        .io_in_data  (io_in_data),
        .io_out_full (io_out_full),
        .a_value     (a_value),
        .io_ready    (io_ready),
        .io_in_rden  (io_in_rden),
        .io_out_wren (io_out_wren),
        .io_out_data (io_out_data)
    );

    alu u_alu (
        .clock   (clock),
        .dec     (dec.sink),
        .a_value (a_value),
        .b_rdata (b_rdata),
        .result  (result)
    );

    // Loading must not overlap a running program or a fetch
    assert property (@(posedge clock) disable iff (!rst_n) imem_wren |-> !(run || fetch_en))
        else $error("instruction memory written while running");

endmodule

// File: src/alu.sv
`timescale 1ns/1ps
/* Result registered every cycle, valid in WRITE. Non-ALU opcodes pass A through */
module alu
    import scalar_pkg::*;
(
    input  logic    clock,
    decoded_if.sink dec,
    input  word_t   a_value,
    input  word_t   b_rdata,
    output word_t   result
);

    word_t result_next;

    // Arithmetic wraps modulo 2^16, no carry
    always_comb begin
        case (dec.op)
            ADD:     result_next = a_value + b_rdata;
            SUB:     result_next = a_value - b_rdata;
            AND:     result_next = a_value & b_rdata;
            OR:      result_next = a_value | b_rdata;
            XOR:     result_next = a_value ^ b_rdata;
            default: result_next = a_value;
        endcase
    end

    always_ff @(posedge clock) begin
        result <= result_next;
    end

endmodule

// File: src/io_ports.sv
`timescale 1ns/1ps
/* One read port on A and one write port on D. Strobes pulse in WRITE against the
   flags of that same cycle. Only the A operand sees offset registers as zero. */
`include "scalar_defines.svh"

module io_ports
    import scalar_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    decoded_if.sink dec,
    input  word_t   a_rdata,
    input  logic    commit,
    input  wb_t     wb,
    input  logic    io_in_empty,
    input  word_t   io_in_data,
    input  logic    io_out_full,
    output word_t   a_value,
    output logic    io_ready,
    output logic    io_in_rden,
    output logic    io_out_wren,
    output word_t   io_out_data
);

    logic a_is_in;
    logic a_is_ofs;
    logic d_is_out;

    assign a_is_in  = (dec.a_addr == `SC_ADDR_IO_IN);
    assign a_is_ofs = dec.a_addr inside {[`SC_ADDR_OFS_A:`SC_ADDR_OFS_D]};
    assign d_is_out = (dec.d_addr == `SC_ADDR_IO_OUT);

    assign a_value = a_is_in  ? io_in_data :
                     a_is_ofs ? '0         : a_rdata;

    // Not ready: reading an empty port, or writing a result to a full one
    assign io_ready = !(a_is_in && io_in_empty) &&
                      !(d_is_out && is_alu_op(dec.op) && io_out_full);

    assign io_in_rden  = commit && a_is_in;
    assign io_out_wren = wb.wren && (wb.addr == `SC_ADDR_IO_OUT);
    assign io_out_data = wb.data;

    assert property (@(posedge clock) disable iff (!rst_n) io_in_rden |-> !io_in_empty)
        else $error("read strobe on empty input port");

    assert property (@(posedge clock) disable iff (!rst_n) io_out_wren |-> !io_out_full)
        else $error("write strobe on full output port");

endmodule

// File: src/addr_translator.sv
`timescale 1ns/1ps
/* Raw A, B and D below SC_XLATE_LIMIT get their default offset added, modulo the limit.
   Offsets written at the end of WRITE apply from the next instruction on. */
`include "scalar_defines.svh"

module addr_translator
    import scalar_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  logic         decode_en,
    input  instr_t       instr,
    input  wb_t          wb,
    decoded_if.source    dec
);

    addr_t ofs_a;
    addr_t ofs_b;
    addr_t ofs_d;

    function automatic addr_t translate(addr_t raw, addr_t ofs);
        addr_t sum;
        sum = raw + ofs;
        if (raw < addr_t'(`SC_XLATE_LIMIT)) begin
            return sum % addr_t'(`SC_XLATE_LIMIT);
        end
        return raw;
    endfunction

    // ----------------------------------------------------------
    // Default offset registers

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ofs_a <= '0;
            ofs_b <= '0;
            ofs_d <= '0;
        end else if (wb.wren) begin
            case (wb.addr)
                `SC_ADDR_OFS_A: ofs_a <= wb.data[`SC_ADDR_WIDTH-1:0];
                `SC_ADDR_OFS_B: ofs_b <= wb.data[`SC_ADDR_WIDTH-1:0];
                `SC_ADDR_OFS_D: ofs_d <= wb.data[`SC_ADDR_WIDTH-1:0];
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Decoded fields, held until the next DECODE

    always_ff @(posedge clock) begin
        if (decode_en) begin
            dec.op     <= instr.op;
            dec.d_raw  <= instr.d;
            dec.a_addr <= translate(instr.a, ofs_a);
            dec.b_addr <= translate(instr.b, ofs_b);
            dec.d_addr <= translate(instr.d, ofs_d);
        end
    end

endmodule

// File: src/sequencer.sv
`timescale 1ns/1ps
/* One instruction in flight, four cycles each whether committed or annulled.
   An annulled instruction keeps pc and is fetched again. */
module sequencer
    import scalar_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  logic    run,
    input  logic    io_ready,
    input  word_t   a_value,
    input  word_t   result,
    decoded_if.sink dec,
    output addr_t   pc,
    output logic    fetch_en,
    output logic    decode_en,
    output wb_t     wb,
    output logic    commit,
    output logic    halted
);

    typedef enum logic [1:0] {FETCH, DECODE, OPERAND, WRITE} state_t;

    state_t state;
    addr_t  pc_next;

    assign fetch_en  = (state == FETCH) && run && !halted;
    assign decode_en = (state == DECODE);
    assign commit    = (state == WRITE) && io_ready;

    // Results go to both data memories at D
    assign wb = '{wren: commit && is_alu_op(dec.op), addr: dec.d_addr, data: result};

    // ----------------------------------------------------------
    // Program control

    always_comb begin
        pc_next = pc + addr_t'(1);
        case (dec.op)
            JMP: begin
                pc_next = dec.d_raw;
            end
            JZ: begin
                if (a_value == '0) begin
                    pc_next = dec.d_raw;
                end
            end
            HALT: begin
                pc_next = pc;
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------
    // FSM

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state  <= FETCH;
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetch_en) begin
                        state <= DECODE;
                    end
                end
                DECODE:  state <= OPERAND;
                OPERAND: state <= WRITE;
                WRITE: begin
                    state <= FETCH;
                    if (commit) begin
                        pc <= pc_next;
                        if (dec.op == HALT) begin
                            halted <= 1'b1;
                        end
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // An annulled instruction or an idle cycle leaves pc alone
    assert property (@(posedge clock) disable iff (!rst_n) !commit |=> $stable(pc))
        else $error("pc moved without a commit");

    assert property (@(posedge clock) disable iff (!rst_n) halted |=> $stable(pc))
        else $error("pc moved while halted");

endmodule

// File: src/sync_ram.sv
`timescale 1ns/1ps
/* Clocked write, combinational read from an address the caller holds in a register.
   No reset on the array, contents are unknown until written. */
`include "scalar_defines.svh"

module sync_ram
    import scalar_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = `SC_MEM_DEPTH
)
(
    input  logic   clock,
    input  logic   wren,
    input  addr_t  waddr,
    input  entry_t wdata,
    input  addr_t  raddr,
    output entry_t rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

    // A write with an unknown address would corrupt an unknown entry
    assert property (@(posedge clock) wren |-> !$isunknown(waddr))
        else $error("sync_ram write with unknown address");

endmodule

// File: src/decoded_if.sv
`timescale 1ns/1ps
/* Fields latched by the translator in DECODE, stable through OPERAND and WRITE */
interface decoded_if
    import scalar_pkg::*;
();
    opcode_t op;
    addr_t   a_addr;
    addr_t   b_addr;
    addr_t   d_addr;
    // Untranslated D, used as the jump target
    addr_t   d_raw;

    modport source (
        output op, a_addr, b_addr, d_addr, d_raw
    );

    modport sink (
        input op, a_addr, b_addr, d_addr, d_raw
    );
endinterface

// File: src/scalar_pkg.sv
/* Types of the scalar core. Opcodes 9 to 15 are not listed and behave as NOP */
package scalar_pkg;

`include "scalar_defines.svh"

    typedef logic [`SC_WORD_WIDTH-1:0] word_t;
    typedef logic [`SC_ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [`SC_OP_WIDTH-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        JMP  = 4'd6,
        JZ   = 4'd7,
        HALT = 4'd8
    } opcode_t;

    // 22 bits, opcode at the top
    typedef struct packed {
        opcode_t op;
        addr_t   d;
        addr_t   a;
        addr_t   b;
    } instr_t;

    typedef struct packed {
        logic  wren;
        addr_t addr;
        word_t data;
    } wb_t;

    // Opcodes that write a result to D
    function automatic logic is_alu_op(opcode_t op);
        return op inside {ADD, SUB, AND, OR, XOR};
    endfunction

endpackage

// File: src/scalar_defines.svh
/* Widths and memory map of the scalar core. Raw addresses below SC_XLATE_LIMIT
   are offset-translated; everything at or above it is absolute. */
`ifndef SCALAR_DEFINES_SVH
`define SCALAR_DEFINES_SVH

`define SC_WORD_WIDTH   16
`define SC_ADDR_WIDTH   6
`define SC_OP_WIDTH     4
`define SC_MEM_DEPTH    64
`define SC_XLATE_LIMIT  32

// Offset registers, write-only
`define SC_ADDR_OFS_A   56
`define SC_ADDR_OFS_B   57
`define SC_ADDR_OFS_D   58

// Memory-mapped I/O
`define SC_ADDR_IO_IN   60
`define SC_ADDR_IO_OUT  61

`endif
